/* source/accel_tile_pkg.sv */
// ##########################################################
// Word-interleaved local memory map, 32-bit word ports only
// L1 geometry sets the local region size, base must be aligned
// ##########################################################
package accel_tile_pkg;

  // Word port geometry
  localparam int unsigned DATA_W = 32;                     // Data word width
  localparam int unsigned BYTE_W = 8;                      // Bits per byte lane
  localparam int unsigned BE_W   = DATA_W / BYTE_W;        // Byte enables per word
  localparam int unsigned ADDR_W = 32;                     // Byte address width

  // Scratchpad geometry
  localparam int unsigned N_BANKS    = 8;                  // Interleaved banks
  localparam int unsigned N_ROWS     = 64;                 // Words per bank
  localparam int unsigned OFFS_W     = $clog2(BE_W);       // Byte offset in a word
  localparam int unsigned BANK_IDX_W = $clog2(N_BANKS);    // Bank select field
  localparam int unsigned ROW_W      = $clog2(N_ROWS);     // Row field
  localparam int unsigned TAG_W      = ADDR_W - ROW_W - BANK_IDX_W - OFFS_W;
  localparam int unsigned N_L1_PORTS = 2;                  // Processor and accelerator

  // Address map
  localparam logic [ADDR_W-1:0] L1_BASE = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] L1_SIZE = ADDR_W'(N_BANKS * N_ROWS * BE_W); // 2 KiB
  localparam logic [ADDR_W-1:0] L1_END  = L1_BASE + L1_SIZE - 1'b1;          // Inclusive
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h1C00_0000;
  localparam logic [ADDR_W-1:0] L2_END  = 32'h1CFF_FFFF;                     // Inclusive

  // Router limits
  localparam int unsigned N_MAX_TRAN = 2;                  // Outstanding transactions
  localparam int unsigned CNT_W      = $clog2(N_MAX_TRAN + 1);

  // Request of a master-to-slave word port
  typedef struct packed {
    logic              req;                                // Request valid
    logic              we;                                 // Write when high
    logic [BE_W-1:0]   be;                                 // Byte enables
    logic [ADDR_W-1:0] addr;                               // Byte address
    logic [DATA_W-1:0] wdata;                              // Write data
  } mem_req_t;

  // Response of the same port
  typedef struct packed {
    logic              gnt;                                // Request accepted
    logic              rvalid;                             // Response valid
    logic [DATA_W-1:0] rdata;                              // Read data
    logic              err;                                // Access error
  } mem_rsp_t;

  // Field view of a local address, low bits select the bank
  typedef struct packed {
    logic [TAG_W-1:0]      tag;                            // Upper bits, unused locally
    logic [ROW_W-1:0]      row;                            // Word inside the bank
    logic [BANK_IDX_W-1:0] bank;                           // Bank index
    logic [OFFS_W-1:0]     byte_offs;                      // Byte in the word
  } l1_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] flat;                               // Compared against the map
    l1_addr_fields_t   f;                                  // Bank and row split
  } l1_addr_u;

  // One bank's request
  typedef struct packed {
    logic              req;                                // Access this cycle
    logic              we;                                 // Write when high
    logic [BE_W-1:0]   be;                                 // Byte enables
    logic [ROW_W-1:0]  row;                                // Row address
    logic [DATA_W-1:0] wdata;                              // Write data
  } bank_req_t;

  // Processor port targets
  typedef enum logic [1:0] {
    ROUTE_L1,                                              // Local scratchpad
    ROUTE_L2,                                              // External L2
    ROUTE_ERR                                              // Unmapped address
  } route_e;

endpackage

/* source/core_addr_router.sv */
`timescale 1ns/100ps
// ##########################################################
// Only one target is in flight at a time so responses stay in order
// L2 slave must follow req/gnt/rvalid and never drop a response
// ##########################################################
module core_addr_router
  import accel_tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rstn_i,
  input  mem_req_t core_req_i,                             // Processor data port
  output mem_rsp_t core_rsp_o,
  output mem_req_t l1_req_o,                               // Toward local interconnect
  input  mem_rsp_t l1_rsp_i,
  output mem_req_t l2_req_o,                               // Toward external L2
  input  mem_rsp_t l2_rsp_i
);

  l1_addr_u         addr_u;                                // Address of the pending request
  route_e           route_d;                               // Target of the pending request
  route_e           route_q;                               // Target of outstanding transactions
  logic [CNT_W-1:0] cnt_q;                                 // Outstanding transactions
  logic [CNT_W-1:0] cnt_d;
  logic             can_issue;                             // Back-pressure allows a grant
  logic             accept;                                // Request handshake done
  logic             rsp_done;                              // Response handed to the processor
  logic             err_pend_q;                            // Error response due this cycle

  assign addr_u = core_req_i.addr;

  // Address map decode
  always_comb begin : route_decode
    if ((addr_u.flat >= L1_BASE) && (addr_u.flat <= L1_END)) begin
      route_d = ROUTE_L1;
    end else if ((addr_u.flat >= L2_BASE) && (addr_u.flat <= L2_END)) begin
      route_d = ROUTE_L2;
    end else begin
      route_d = ROUTE_ERR;
    end
  end

  // Empty pipe, or same target with room left
  assign can_issue = (cnt_q == '0) ||
                     ((cnt_q < CNT_W'(N_MAX_TRAN)) && (route_q == route_d));

  // Forward only to the decoded target
  always_comb begin : req_fwd
    l1_req_o     = core_req_i;
    l2_req_o     = core_req_i;
    l1_req_o.req = core_req_i.req & can_issue & (route_d == ROUTE_L1);
    l2_req_o.req = core_req_i.req & can_issue & (route_d == ROUTE_L2);
  end

  always_comb begin : rsp_mux
    case (route_d)
      ROUTE_L1: core_rsp_o.gnt = core_req_i.req & can_issue & l1_rsp_i.gnt;
      ROUTE_L2: core_rsp_o.gnt = core_req_i.req & can_issue & l2_rsp_i.gnt;
      default:  core_rsp_o.gnt = core_req_i.req & can_issue; // Error target grants at once
    endcase
    core_rsp_o.rvalid = 1'b0;
    core_rsp_o.rdata  = '0;
    core_rsp_o.err    = 1'b0;
    if (cnt_q != '0) begin                                 // Responses only when something is out
      case (route_q)
        ROUTE_L1: begin
          core_rsp_o.rvalid = l1_rsp_i.rvalid;
          core_rsp_o.rdata  = l1_rsp_i.rdata;
          core_rsp_o.err    = l1_rsp_i.err;
        end
        ROUTE_L2: begin
          core_rsp_o.rvalid = l2_rsp_i.rvalid;
          core_rsp_o.rdata  = l2_rsp_i.rdata;
          core_rsp_o.err    = l2_rsp_i.err;
        end
        default: begin
          core_rsp_o.rvalid = err_pend_q;
          core_rsp_o.err    = err_pend_q;              // Read data stays zero
        end
      endcase
    end
  end

  assign accept   = core_req_i.req & core_rsp_o.gnt;
  assign rsp_done = core_rsp_o.rvalid;

  always_comb begin : cnt_next
    cnt_d = cnt_q;
    if (accept && !rsp_done) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!accept && rsp_done) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin : track_ff
    if (!rstn_i) begin
      cnt_q      <= '0;
      route_q    <= ROUTE_L1;
      err_pend_q <= 1'b0;
    end else begin
      cnt_q      <= cnt_d;
      err_pend_q <= accept & (route_d == ROUTE_ERR);   // One cycle error latency
      if (accept) begin
        route_q <= route_d;                            // Same route or empty pipe
      end
    end
  end

endmodule

/* source/l1_interconnect.sv */
`timescale 1ns/100ps
// ##########################################################
// Two word ports over N_BANKS banks, grant is combinational
// Only bank and row bits are decoded, the caller checks the region
// ##########################################################
module l1_interconnect
  import accel_tile_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rstn_i,
  input  logic                            tile_enable_i,   // Local side enable
  input  mem_req_t                        core_req_i,      // Port 0
  input  mem_req_t                        accel_req_i,     // Port 1
  output mem_rsp_t                        core_rsp_o,
  output mem_rsp_t                        accel_rsp_o,
  output bank_req_t [N_BANKS-1:0]         bank_req_o,      // One request per bank
  input  logic [N_BANKS-1:0][DATA_W-1:0]  bank_rdata_i     // Registered bank outputs
);

  mem_req_t [N_L1_PORTS-1:0]                  port_req;    // Index 0 core, 1 accel
  mem_rsp_t [N_L1_PORTS-1:0]                  port_rsp;
  l1_addr_u [N_L1_PORTS-1:0]                  port_addr;   // Bank view of each address
  logic [N_L1_PORTS-1:0][N_BANKS-1:0]         want;        // Port requests bank
  logic [N_BANKS-1:0]                         bank_busy;   // Some port wants the bank
  logic [N_BANKS-1:0]                         win_port;    // Winner index per bank
  logic [N_BANKS-1:0]                         last_q;      // Last winner per bank
  logic [N_L1_PORTS-1:0]                      port_gnt;
  logic [N_L1_PORTS-1:0]                      rvalid_q;    // Grant delayed by one cycle
  logic [N_L1_PORTS-1:0][BANK_IDX_W-1:0]      bank_q;      // Bank that serves the response
  logic                                       en_q;        // Registered tile enable

  assign port_req    = {accel_req_i, core_req_i};
  assign core_rsp_o  = port_rsp[0];
  assign accel_rsp_o = port_rsp[1];

  // Bank selection, nothing wanted while disabled
  always_comb begin : bank_decode
    for (int p = 0; p < N_L1_PORTS; p++) begin
      port_addr[p]                 = port_req[p].addr;
      want[p]                      = '0;
      want[p][port_addr[p].f.bank] = en_q & port_req[p].req;
    end
  end

  // Per-bank round robin between the two ports
  always_comb begin : arbiter
    port_gnt = '0;
    for (int b = 0; b < N_BANKS; b++) begin
      bank_busy[b] = want[0][b] | want[1][b];
      win_port[b]  = want[1][b] & (~want[0][b] | ~last_q[b]); // Accel unless it won last
      if (bank_busy[b]) begin
        port_gnt[win_port[b]] = 1'b1;
      end
    end
  end

  // Winner's fields go to the bank
  always_comb begin : bank_mux
    for (int b = 0; b < N_BANKS; b++) begin
      bank_req_o[b].req   = bank_busy[b];
      bank_req_o[b].we    = port_req[win_port[b]].we;
      bank_req_o[b].be    = port_req[win_port[b]].be;
      bank_req_o[b].row   = port_addr[win_port[b]].f.row;
      bank_req_o[b].wdata = port_req[win_port[b]].wdata;
    end
  end

  always_ff @(posedge clk_i or negedge rstn_i) begin : ctrl_ff
    if (!rstn_i) begin
      en_q     <= 1'b0;
      last_q   <= '0;
      rvalid_q <= '0;
    end else begin
      en_q     <= tile_enable_i;
      rvalid_q <= port_gnt;                            // Bank data is ready next cycle
      for (int b = 0; b < N_BANKS; b++) begin
        if (bank_busy[b]) begin
          last_q[b] <= win_port[b];
        end
      end
    end
  end

  // Remember which bank to read back
  always_ff @(posedge clk_i) begin : bank_sel_ff
    for (int p = 0; p < N_L1_PORTS; p++) begin
      if (port_gnt[p]) begin
        bank_q[p] <= port_addr[p].f.bank;
      end
    end
  end

  always_comb begin : rsp_build
    for (int p = 0; p < N_L1_PORTS; p++) begin
      port_rsp[p].gnt    = port_gnt[p];
      port_rsp[p].rvalid = rvalid_q[p];
      port_rsp[p].rdata  = bank_rdata_i[bank_q[p]];
      port_rsp[p].err    = 1'b0;                       // Local accesses never fail
    end
  end

endmodule

/* source/l1_spm.sv */
`timescale 1ns/100ps
// ##########################################################
// Contents are not initialised, reads have one cycle latency
// ##########################################################
module l1_spm
  import accel_tile_pkg::*;
(
  input  logic                           clk_i,
  input  bank_req_t [N_BANKS-1:0]        bank_req_i,       // One request per bank
  output logic [N_BANKS-1:0][DATA_W-1:0] bank_rdata_o      // Word read on the last access
);

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    logic [DATA_W-1:0] mem [N_ROWS];                       // Bank storage
    logic [DATA_W-1:0] rdata_q;                            // Output register

    always_ff @(posedge clk_i) begin : rw_ff
      if (bank_req_i[b].req) begin
        rdata_q <= mem[bank_req_i[b].row];                 // Old word also on writes
        if (bank_req_i[b].we) begin
          for (int i = 0; i < BE_W; i++) begin
            if (bank_req_i[b].be[i]) begin
              mem[bank_req_i[b].row][i*BYTE_W +: BYTE_W] <=
                bank_req_i[b].wdata[i*BYTE_W +: BYTE_W];   // Byte lane write
            end
          end
        end
      end
    end

    assign bank_rdata_o[b] = rdata_q;
  end

endmodule

/* source/accel_tile.sv */
`timescale 1ns/100ps
// ##########################################################
// Local side is idle until tile_enable_i was high on an edge
// Accelerator port reaches only the scratchpad
// ##########################################################
module accel_tile
  import accel_tile_pkg::*;
(
  input  logic     clk_i,
  input  logic     rstn_i,
  input  logic     tile_enable_i,                          // Enables local grants
  input  mem_req_t core_req_i,                             // Processor data port
  output mem_rsp_t core_rsp_o,
  input  mem_req_t accel_req_i,                            // Accelerator memory port
  output mem_rsp_t accel_rsp_o,
  output mem_req_t l2_req_o,                               // External L2 port
  input  mem_rsp_t l2_rsp_i
);

  mem_req_t                       core_l1_req;             // Router to interconnect
  mem_rsp_t                       core_l1_rsp;
  bank_req_t [N_BANKS-1:0]        bank_req;                // Interconnect to banks
  logic [N_BANKS-1:0][DATA_W-1:0] bank_rdata;              // Banks back to interconnect

  // Processor address split
  core_addr_router core_addr_router_inst (
    .clk_i      ( clk_i       ),
    .rstn_i     ( rstn_i      ),
    .core_req_i ( core_req_i  ),
    .core_rsp_o ( core_rsp_o  ),
    .l1_req_o   ( core_l1_req ),
    .l1_rsp_i   ( core_l1_rsp ),
    .l2_req_o   ( l2_req_o    ),
    .l2_rsp_i   ( l2_rsp_i    )
  );

  // Bank arbitration between processor and accelerator
  l1_interconnect l1_interconnect_inst (
    .clk_i         ( clk_i         ),
    .rstn_i        ( rstn_i        ),
    .tile_enable_i ( tile_enable_i ),
    .core_req_i    ( core_l1_req   ),
    .accel_req_i   ( accel_req_i   ),
    .core_rsp_o    ( core_l1_rsp   ),
    .accel_rsp_o   ( accel_rsp_o   ),
    .bank_req_o    ( bank_req      ),
    .bank_rdata_i  ( bank_rdata    )
  );

  // Banked scratchpad
  l1_spm l1_spm_inst (
    .clk_i        ( clk_i      ),
    .bank_req_i   ( bank_req   ),
    .bank_rdata_o ( bank_rdata )
  );

endmodule

/* include/tile_test_table.svh */
// ##########################################################
// Included in the testbench module after the package import
// Local words are written in full before the first read
// ##########################################################
`ifndef TILE_TEST_TABLE_SVH
`define TILE_TEST_TABLE_SVH

localparam logic P_CORE = 1'b0;                            // Processor data port
localparam logic P_ACC  = 1'b1;                            // Accelerator memory port
localparam logic RD     = 1'b0;
localparam logic WR     = 1'b1;
localparam logic SOLO   = 1'b0;                            // One access only
localparam logic DUAL   = 1'b1;                            // Second access on the other port

typedef struct packed {
  logic              port;                                 // Port of the first access
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   be;
  logic              dual;                                 // Same-cycle access on other port
  logic              we2;
  logic [ADDR_W-1:0] addr2;
  logic [DATA_W-1:0] wdata2;
  logic [BE_W-1:0]   be2;
} test_entry_t;

localparam int N_TESTS = 25;

// Columns: port, op, address, wdata, be, tag, then op, address, wdata, be of the second access
localparam test_entry_t TEST_TABLE [N_TESTS] = '{
  // Processor writes and reads, full and partial words
  '{P_CORE, WR, 32'h1000_0000, 32'h1122_3344, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1000_0000, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, WR, 32'h1000_0000, 32'hAABB_CCDD, 4'h5, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1000_0000, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, WR, 32'h1000_0024, 32'hCAFE_F00D, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, WR, 32'h1000_0024, 32'h0099_0000, 4'h4, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1000_0024, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  // Words shared between the two ports
  '{P_ACC,  WR, 32'h1000_0048, 32'h0BAD_BEEF, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1000_0048, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, WR, 32'h1000_07FC, 32'h7654_3210, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_ACC,  RD, 32'h1000_07FC, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_ACC,  WR, 32'h1000_07FC, 32'h0000_00EE, 4'h1, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1000_07FC, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  // Both ports in one cycle, bank 0 twice, then banks 0 and 2, then bank 1
  '{P_CORE, WR, 32'h1000_0060, 32'h1357_9BDF, 4'hF,
    DUAL, WR, 32'h1000_0100, 32'h2468_ACE0, 4'hF},
  '{P_CORE, RD, 32'h1000_0100, 32'h0000_0000, 4'hF,
    DUAL, RD, 32'h1000_0060, 32'h0000_0000, 4'hF},
  '{P_CORE, RD, 32'h1000_0000, 32'h0000_0000, 4'hF,
    DUAL, RD, 32'h1000_0048, 32'h0000_0000, 4'hF},
  '{P_CORE, RD, 32'h1000_0024, 32'h0000_0000, 4'hF,
    DUAL, WR, 32'h1000_0124, 32'h5A5A_5A5A, 4'hF},
  // External L2 region
  '{P_CORE, WR, 32'h1C00_0100, 32'hDEAD_BEEF, 4'h3, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1C00_0100, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1CFF_FFFC, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h1000_0100, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  // Unmapped addresses, one just past the local region
  '{P_CORE, RD, 32'h2000_0000, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, WR, 32'h1000_0800, 32'h0000_0001, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_CORE, RD, 32'h0000_0010, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0},
  '{P_ACC,  RD, 32'h1000_0124, 32'h0000_0000, 4'hF, SOLO, RD, '0, '0, '0}
};

`endif

/* sim/accel_tile_tb.sv */
`timescale 1ns/100ps
// ############################################################
// One access per port at a time and one pending L2 request
// Outputs are sampled on the rising edge before any update
// ############################################################
module accel_tile_tb
  import accel_tile_pkg::*;
();

  `include "tile_test_table.svh"

  localparam int TIMEOUT_CYC = N_TESTS * 12 + 100;          // Run limit in cycles
  localparam int N_WORDS     = N_BANKS * N_ROWS;

  logic              clk_i         = 1'b0;
  logic              rstn_i        = 1'b0;
  logic              tile_enable_i = 1'b0;                  // Local side off after reset
  mem_req_t          core_req      = '0;
  mem_req_t          accel_req     = '0;
  mem_rsp_t          l2_rsp        = '0;
  mem_rsp_t          core_rsp;
  mem_rsp_t          accel_rsp;
  mem_req_t          l2_req;
  logic [DATA_W-1:0] ref_mem [N_WORDS];                     // Expected scratchpad words
  int                cycle_cnt     = 0;
  int                err_cnt       = 0;
  int                check_cnt     = 0;
  int                l2_cnt        = 0;                     // Accepted L2 requests
  mem_req_t          l2_seen       = '0;                    // Last accepted L2 request
  logic              l2_pend       = 1'b0;
  logic [2:0]        l2_wait       = '0;                    // Cycles left to the L2 answer
  logic [31:0]       lcg_state     = 32'h5a7c;

  always #20 clk_i = ~clk_i;                                // 40 ns period

  accel_tile accel_tile_inst (
    .clk_i         ( clk_i         ),
    .rstn_i        ( rstn_i        ),
    .tile_enable_i ( tile_enable_i ),
    .core_req_i    ( core_req      ),
    .core_rsp_o    ( core_rsp      ),
    .accel_req_i   ( accel_req     ),
    .accel_rsp_o   ( accel_rsp     ),
    .l2_req_o      ( l2_req        ),
    .l2_rsp_i      ( l2_rsp        )
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word the L2 model returns for a read
  function automatic logic [DATA_W-1:0] l2_read_word(input logic [ADDR_W-1:0] a);
    return {a[15:0], a[31:16]} ^ 32'hC3A5_5A3C;            // Every address bit counts
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];                    // Enabled lane takes new byte
      end
    end
    return res;
  endfunction

  function automatic route_e target_of(input logic [ADDR_W-1:0] a);
    route_e r;
    r = ROUTE_ERR;
    if (a >= L1_BASE && a <= L1_END) begin
      r = ROUTE_L1;
    end else if (a >= L2_BASE && a <= L2_END) begin
      r = ROUTE_L2;
    end
    return r;
  endfunction

  function automatic mem_rsp_t port_rsp(input logic port);
    return port ? accel_rsp : core_rsp;
  endfunction

  task automatic drive_port(input logic port, input mem_req_t r);
    if (port) begin
      accel_req <= r;
    end else begin
      core_req <= r;
    end
  endtask

  task automatic flag_error(input string msg);
    err_cnt++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // One access from request to response and all checks on it
  task automatic do_access(input logic port, input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be);
    mem_rsp_t          rsp;
    route_e            route;
    int                l2_before;
    int                gnt_cyc;
    int                idx;
    logic [DATA_W-1:0] exp;
    route     = port ? ROUTE_L1 : target_of(addr);          // Accelerator sees only L1
    l2_before = l2_cnt;
    idx       = int'((addr - L1_BASE) >> 2);                // Word index in the region
    @(posedge clk_i);
    drive_port(port, '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata});
    do begin
      @(posedge clk_i);
      rsp = port_rsp(port);
    end while (!rsp.gnt);
    drive_port(port, '0);                                   // Accepted on this edge
    gnt_cyc = cycle_cnt;
    do begin
      @(posedge clk_i);
      rsp = port_rsp(port);
    end while (!rsp.rvalid);
    check_cnt++;
    if (rsp.err !== (route == ROUTE_ERR)) begin
      flag_error($sformatf("port %0d addr %h err %b", port, addr, rsp.err));
    end
    if (route != ROUTE_L2 && cycle_cnt - gnt_cyc != 1) begin
      flag_error($sformatf("port %0d addr %h rvalid %0d cycles after gnt, expected 1",
                           port, addr, cycle_cnt - gnt_cyc));
    end
    if (route == ROUTE_L2) begin
      if (l2_cnt != l2_before + 1 || l2_seen.addr !== addr || l2_seen.we !== we ||
          l2_seen.be !== be || l2_seen.wdata !== wdata) begin
        flag_error($sformatf("L2 request addr %h be %h wdata %h, expected %h %h %h",
                             l2_seen.addr, l2_seen.be, l2_seen.wdata, addr, be, wdata));
      end
    end else if (l2_cnt != l2_before) begin
      flag_error($sformatf("unexpected L2 request for addr %h", addr));
    end
    exp = (route == ROUTE_L1) ? ref_mem[idx] : l2_read_word(addr);
    if (!we && route != ROUTE_ERR && rsp.rdata !== exp) begin
      flag_error($sformatf("port %0d addr %h rdata %h, expected %h", port, addr, rsp.rdata, exp));
    end
    if (we && route == ROUTE_L1) begin
      ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, be);
    end
  endtask

  task automatic run_entry(input test_entry_t t);
    if (t.dual) begin
      fork                                                  // Same start edge on both ports
        do_access(t.port, t.we, t.addr, t.wdata, t.be);
        do_access(~t.port, t.we2, t.addr2, t.wdata2, t.be2);
      join
    end else begin
      do_access(t.port, t.we, t.addr, t.wdata, t.be);
    end
  endtask

  // L2 model that always grants and answers after 1 to 4 cycles
  always @(posedge clk_i or negedge rstn_i) begin : l2_responder
    if (!rstn_i) begin
      l2_rsp    <= '0;
      l2_pend   <= 1'b0;
      l2_wait   <= '0;
      l2_cnt    <= 0;
      lcg_state <= 32'h5a7c;
    end else begin
      l2_rsp.gnt    <= 1'b1;
      l2_rsp.rvalid <= 1'b0;
      l2_rsp.rdata  <= '0;
      l2_rsp.err    <= 1'b0;
      if (l2_req.req && l2_rsp.gnt) begin
        l2_seen   <= l2_req;
        l2_cnt    <= l2_cnt + 1;
        l2_pend   <= 1'b1;
        l2_wait   <= 3'd1 + {1'b0, lcg_state[31:30]};      // Upper LCG bits
        lcg_state <= lcg_next(lcg_state);
      end else if (l2_pend) begin
        if (l2_wait == 3'd1) begin
          l2_rsp.rvalid <= 1'b1;
          l2_rsp.rdata  <= l2_seen.we ? '0 : l2_read_word(l2_seen.addr);
          l2_pend       <= 1'b0;
        end else begin
          l2_wait <= l2_wait - 3'd1;
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: no finish within %0d cycles, a handshake is stuck", TIMEOUT_CYC);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin : main_seq
    repeat (3) @(posedge clk_i);
    rstn_i <= 1'b1;
    @(posedge clk_i);
    accel_req <= '{req: 1'b1, we: 1'b0, be: 4'hF, addr: L1_BASE, wdata: '0};
    repeat (4) begin                                        // Tile still disabled
      @(posedge clk_i);
      check_cnt++;
      if (accel_rsp.gnt || accel_rsp.rvalid) begin
        flag_error("grant or response on the accelerator port while the tile is disabled");
      end
    end
    accel_req     <= '0;
    tile_enable_i <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      run_entry(TEST_TABLE[i]);
    end
    @(posedge clk_i);
    $display("Done: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* accel_tile.f */
+incdir+include
source/accel_tile_pkg.sv
source/core_addr_router.sv
source/l1_interconnect.sv
source/l1_spm.sv
source/accel_tile.sv
sim/accel_tile_tb.sv

/* Makefile */
# Verilator build and run of the accel_tile testbench

TOP := accel_tile_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f accel_tile.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully" || exit 1

clean:
	rm -rf obj_dir
